// File: Makefile
.PHONY: sim clean

BIN := rgmii_bridge_sim
LOG := sim.log

sim:
	verilator --binary --timing --assert -f sources.f --top-module rgmii_bridge_tb -o $(BIN)
	./obj_dir/$(BIN) > $(LOG) 2>&1 || true
	cat $(LOG)
	! grep -q "Done: errors found" $(LOG)
	grep -q "Done: no errors" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

// File: source/gmii_byte_fifo.sv
module gmii_byte_fifo #(
	parameter int unsigned FIFO_DEPTH = 16
) (
	input  logic                 gmii_rxc,
	input  logic                 oserdes_rst,
	input  logic                 wr,
	input  gmii_pkg::fifo_word_t wr_word,
	input  logic                 rd,
	output gmii_pkg::fifo_word_t rd_word,
	output logic                 empty,
	output logic                 full
);

	import gmii_pkg::*;

	// Pointer width, one bit more for the occupancy count
	localparam int unsigned AW = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
	localparam logic [AW:0] DEPTH_CNT = (AW + 1)'(FIFO_DEPTH);
	localparam logic [AW-1:0] LAST_PTR = AW'(FIFO_DEPTH - 1);

	// Storage
	fifo_word_t mem [FIFO_DEPTH];

	logic [AW-1:0] wr_ptr;
	logic [AW-1:0] rd_ptr;
	logic [AW:0]   count;

	// Accepted operations
	logic do_wr;
	logic do_rd;

	assign empty = (count == '0);
	assign full  = (count == DEPTH_CNT);

	// Writes into a full buffer are dropped
	assign do_wr = wr & ~full;
	assign do_rd = rd & ~empty;

	////////////////////////////////////////////////////////////
	// Data path

	always_ff @(posedge gmii_rxc) begin
		if (do_wr) begin
			mem[wr_ptr] <= wr_word;
		end
	end

	// Registered read port, word valid the cycle after rd
	always_ff @(posedge gmii_rxc) begin
		if (do_rd) begin
			rd_word <= mem[rd_ptr];
		end
	end

	////////////////////////////////////////////////////////////
	// Pointers and count

	always_ff @(posedge gmii_rxc) begin
		if (oserdes_rst) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			// Wrap explicitly so any depth works
			if (do_wr) begin
				wr_ptr <= (wr_ptr == LAST_PTR) ? '0 : wr_ptr + 1'b1;
			end
			if (do_rd) begin
				rd_ptr <= (rd_ptr == LAST_PTR) ? '0 : rd_ptr + 1'b1;
			end
			case ({do_wr, do_rd})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

endmodule

// File: source/gmii_pkg.sv
package gmii_pkg;

	////////////////////////////////////////////////////////////
	// Link speed

	// Coded as in RGMII in-band status bits 2:1
	typedef enum logic [1:0] {
		LINK_SPEED_10M   = 2'b00,
		LINK_SPEED_100M  = 2'b01,
		LINK_SPEED_1000M = 2'b10
	} lspeed_t;

	////////////////////////////////////////////////////////////
	// Bus types

	// One RGMII clock cycle with both DDR halves side by side
	// Used for the receive pins and for the transmit pins
	typedef struct packed {
		logic [3:0] rxd_rise;
		logic [3:0] rxd_fall;
		logic       ctl_rise;
		logic       ctl_fall;
	} rgmii_ddr_t;

	// Byte-wide GMII receive bus
	// At 10/100 dvalid marks the cycles that carry a whole byte
	typedef struct packed {
		logic       en;
		logic       er;
		logic       dvalid;
		logic [7:0] data;
	} gmii_bus_t;

	// One FIFO entry, a received byte and its error flag
	typedef struct packed {
		logic [7:0] data;
		logic       er;
	} fifo_word_t;

endpackage

// File: source/link_pkg.sv
package link_pkg;

	////////////////////////////////////////////////////////////
	// In-band status

	// Link state decoded from the inter-frame gap
	typedef struct packed {
		logic              link_up;
		gmii_pkg::lspeed_t link_speed;
		logic              false_carrier;
	} link_status_t;

	// Error symbol sent by the PHY during the gap on false carrier
	localparam logic [7:0] INBAND_FALSE_CARRIER = 8'h0E;

	////////////////////////////////////////////////////////////
	// Transmit side

	// Encoder FSM states
	typedef enum logic [1:0] {
		TX_IDLE,
		TX_LOW_NIBBLE,
		TX_HIGH_NIBBLE
	} tx_state_t;

	// Forwarded clock patterns, LSB leaves first
	localparam logic [3:0] TXC_PATTERN_GIG  = 4'b1001;
	localparam logic [3:0] TXC_PATTERN_LOW  = 4'b0000;
	localparam logic [3:0] TXC_PATTERN_HIGH = 4'b1111;

	// Cycles per nibble at 100M and half a clock period at 10M
	localparam int unsigned TX_100M_DIV = 5;
	localparam int unsigned TX_10M_HALF = 25;

endpackage

// File: source/rgmii_loopback_bridge.sv
module rgmii_loopback_bridge #(
	parameter int unsigned FIFO_DEPTH = 16
) (
	input  logic                   gmii_rxc,
	input  logic                   oserdes_rst,
	input  gmii_pkg::rgmii_ddr_t   rgmii_rx,
	output gmii_pkg::rgmii_ddr_t   rgmii_tx,
	output logic [3:0]             txc_pattern,
	output link_pkg::link_status_t link_status
);

	import gmii_pkg::*;

	// Decoder output bus
	gmii_bus_t  gmii_rx;

	// FIFO ports
	fifo_word_t wr_word;
	fifo_word_t rd_word;
	logic       wr;
	logic       rd;
	logic       empty;
	logic       full;

	////////////////////////////////////////////////////////////
	// Receive path

	rgmii_rx_decoder rx_dec_i (
		.gmii_rxc    (gmii_rxc),
		.oserdes_rst (oserdes_rst),
		.rgmii_rx    (rgmii_rx),
		.gmii_rx     (gmii_rx),
		.link_status (link_status)
	);

	// Only whole bytes inside a frame enter the buffer
	assign wr      = gmii_rx.en & gmii_rx.dvalid;
	assign wr_word = '{data: gmii_rx.data, er: gmii_rx.er};

	gmii_byte_fifo #(
		.FIFO_DEPTH (FIFO_DEPTH)
	) fifo_i (
		.gmii_rxc    (gmii_rxc),
		.oserdes_rst (oserdes_rst),
		.wr          (wr),
		.wr_word     (wr_word),
		.rd          (rd),
		.rd_word     (rd_word),
		.empty       (empty),
		.full        (full)
	);

	////////////////////////////////////////////////////////////
	// Transmit path

	rgmii_tx_encoder tx_enc_i (
		.gmii_rxc    (gmii_rxc),
		.oserdes_rst (oserdes_rst),
		.link_status (link_status),
		.empty       (empty),
		.rd          (rd),
		.rd_word     (rd_word),
		.rgmii_tx    (rgmii_tx),
		.txc_pattern (txc_pattern)
	);

endmodule

// File: source/rgmii_rx_decoder.sv
module rgmii_rx_decoder (
	input  logic                   gmii_rxc,
	input  logic                   oserdes_rst,
	input  gmii_pkg::rgmii_ddr_t   rgmii_rx,
	output gmii_pkg::gmii_bus_t    gmii_rx,
	output link_pkg::link_status_t link_status
);

	import gmii_pkg::*;
	import link_pkg::*;

	// Pin pair after the input register
	rgmii_ddr_t rx_q;

	// Control decode of the registered pair
	logic       en;
	logic       er_int;
	logic [7:0] pair_byte;

	// 10/100 nibble assembly state
	logic [3:0] nib_prev;
	logic       er_prev;
	logic       en_prev;
	logic       phase;
	logic       sof;

	// Next values for the output bus
	logic [7:0] byte_mux;
	logic       dvalid_mux;
	logic       er_mux;

	// False carrier edge detect
	logic       fc_hit;
	logic       fc_hit_q;

	////////////////////////////////////////////////////////////
	// Input capture

	always_ff @(posedge gmii_rxc) begin
		if (oserdes_rst) begin
			rx_q <= '0;
		end else begin
			rx_q <= rgmii_rx;
		end
	end

	// RGMII carries en on the rising half and en^er on the falling half
	assign en        = rx_q.ctl_rise;
	assign er_int    = rx_q.ctl_rise ^ rx_q.ctl_fall;
	assign pair_byte = {rx_q.rxd_fall, rx_q.rxd_rise};

	// First en cycle of a frame
	assign sof = en & ~en_prev;

	////////////////////////////////////////////////////////////
	// Byte assembly

	always_ff @(posedge gmii_rxc) begin
		if (oserdes_rst) begin
			en_prev <= 1'b0;
			phase   <= 1'b0;
		end else begin
			en_prev <= en;
			// Sync on start of frame so the low nibble comes first
			if (sof) begin
				phase <= 1'b1;
			end else begin
				phase <= ~phase;
			end
		end
		// Previous nibble and its error, payload only
		nib_prev <= rx_q.rxd_rise;
		er_prev  <= er_int;
	end

	always_comb begin
		if (link_status.link_speed == LINK_SPEED_1000M) begin
			// Whole byte in one cycle, rise nibble low
			byte_mux   = pair_byte;
			dvalid_mux = en;
			er_mux     = er_int & en;
		end else begin
			// Current nibble is the high half, held one is the low half
			byte_mux   = {rx_q.rxd_rise, nib_prev};
			dvalid_mux = en & ~sof & phase;
			er_mux     = (er_int | er_prev) & en;
		end
	end

	always_ff @(posedge gmii_rxc) begin
		if (oserdes_rst) begin
			gmii_rx.en     <= 1'b0;
			gmii_rx.er     <= 1'b0;
			gmii_rx.dvalid <= 1'b0;
		end else begin
			gmii_rx.en     <= en;
			gmii_rx.er     <= er_mux;
			gmii_rx.dvalid <= dvalid_mux;
		end
		gmii_rx.data <= byte_mux;
	end

	////////////////////////////////////////////////////////////
	// In-band status

	// Error symbol outside a frame flags false carrier
	assign fc_hit = ~en & er_int & (pair_byte == INBAND_FALSE_CARRIER);

	always_ff @(posedge gmii_rxc) begin
		if (oserdes_rst) begin
			link_status.link_up       <= 1'b0;
			link_status.link_speed    <= LINK_SPEED_10M;
			link_status.false_carrier <= 1'b0;
			fc_hit_q                  <= 1'b0;
		end else begin
			fc_hit_q <= fc_hit;
			// Plain gap cycle carries link state and speed
			if (!en && !er_int) begin
				link_status.link_up    <= pair_byte[0];
				link_status.link_speed <= lspeed_t'(pair_byte[2:1]);
			end
			// One pulse per run of the symbol
			link_status.false_carrier <= fc_hit & ~fc_hit_q;
		end
	end

endmodule

// File: source/rgmii_tx_encoder.sv
module rgmii_tx_encoder (
	input  logic                   gmii_rxc,
	input  logic                   oserdes_rst,
	input  link_pkg::link_status_t link_status,
	input  logic                   empty,
	output logic                   rd,
	input  gmii_pkg::fifo_word_t   rd_word,
	output gmii_pkg::rgmii_ddr_t   rgmii_tx,
	output logic [3:0]             txc_pattern
);

	import gmii_pkg::*;
	import link_pkg::*;

	// Last count of each nibble period
	localparam logic [5:0] LAST_100M = 6'(TX_100M_DIV - 1);
	localparam logic [5:0] LAST_10M  = 6'(2 * TX_10M_HALF - 1);

	// 100M clock edge sits mid period, 10M toggles at half period
	localparam logic [5:0] EDGE_100M = 6'(TX_100M_DIV / 2);
	localparam logic [5:0] HALF_10M  = 6'(TX_10M_HALF);

	// Rising edge inside one cycle, low bits leave first
	localparam logic [3:0] TXC_PATTERN_EDGE = 4'b1100;

	tx_state_t  state;
	lspeed_t    speed_q;
	logic [5:0] cnt;
	logic [5:0] cnt_last;
	logic       period_end;
	logic       gig;
	logic       rd_pend;
	logic [3:0] nib;
	logic [3:0] pattern_slow;

	////////////////////////////////////////////////////////////
	// Period counter

	assign gig        = (speed_q == LINK_SPEED_1000M);
	assign cnt_last   = (speed_q == LINK_SPEED_100M) ? LAST_100M : LAST_10M;
	// Compare with >= so a speed change never strands the count
	assign period_end = (cnt >= cnt_last);

	////////////////////////////////////////////////////////////
	// FIFO pop and FSM

	always_comb begin
		rd = 1'b0;
		if (!empty) begin
			case (state)
				// Gig pops each cycle, 10/100 waits for a period boundary
				TX_IDLE:        rd = gig | period_end;
				// Next byte follows straight on inside a frame
				TX_HIGH_NIBBLE: rd = period_end;
				default:        rd = 1'b0;
			endcase
		end
	end

	always_ff @(posedge gmii_rxc) begin
		if (oserdes_rst) begin
			state   <= TX_IDLE;
			speed_q <= LINK_SPEED_10M;
			cnt     <= '0;
			rd_pend <= 1'b0;
		end else begin
			rd_pend <= rd;
			cnt     <= period_end ? '0 : cnt + 6'd1;
			case (state)
				TX_IDLE: begin
					// Speed only follows the link while nothing is in flight
					if (!rd) begin
						speed_q <= link_status.link_speed;
					end
					if (rd && !gig) begin
						state <= TX_LOW_NIBBLE;
					end
				end
				TX_LOW_NIBBLE: begin
					if (period_end) begin
						state <= TX_HIGH_NIBBLE;
					end
				end
				TX_HIGH_NIBBLE: begin
					if (period_end) begin
						state <= rd ? TX_LOW_NIBBLE : TX_IDLE;
					end
				end
				default: state <= TX_IDLE;
			endcase
		end
	end

	////////////////////////////////////////////////////////////
	// Output register

	// Low nibble first at 10/100
	assign nib = (state == TX_HIGH_NIBBLE) ? rd_word.data[7:4] : rd_word.data[3:0];

	always_comb begin
		if (speed_q == LINK_SPEED_100M) begin
			if (cnt < EDGE_100M) begin
				pattern_slow = TXC_PATTERN_LOW;
			end else if (cnt == EDGE_100M) begin
				pattern_slow = TXC_PATTERN_EDGE;
			end else begin
				pattern_slow = TXC_PATTERN_HIGH;
			end
		end else begin
			pattern_slow = (cnt < HALF_10M) ? TXC_PATTERN_LOW : TXC_PATTERN_HIGH;
		end
	end

	// ctl_rise is en, ctl_fall is en^er which is ~er while sending
	always_ff @(posedge gmii_rxc) begin
		if (oserdes_rst) begin
			rgmii_tx    <= '0;
			txc_pattern <= TXC_PATTERN_LOW;
		end else if (gig) begin
			txc_pattern <= TXC_PATTERN_GIG;
			if (rd_pend) begin
				rgmii_tx <= '{rd_word.data[3:0], rd_word.data[7:4], 1'b1, ~rd_word.er};
			end else begin
				rgmii_tx <= '0;
			end
		end else begin
			txc_pattern <= pattern_slow;
			// Same nibble on both halves
			if (state != TX_IDLE) begin
				rgmii_tx <= '{nib, nib, 1'b1, ~rd_word.er};
			end else begin
				rgmii_tx <= '0;
			end
		end
	end

endmodule

// File: sources.f
source/gmii_pkg.sv
source/link_pkg.sv
source/rgmii_rx_decoder.sv
source/gmii_byte_fifo.sv
source/rgmii_tx_encoder.sv
source/rgmii_loopback_bridge.sv
test/rgmii_bridge_assertions.sv
test/rgmii_bridge_tb.sv

// File: test/rgmii_bridge_assertions.sv
module rgmii_bridge_assertions (
	input  logic                   gmii_rxc,
	input  logic                   oserdes_rst,
	input  gmii_pkg::gmii_bus_t    gmii_rx,
	input  link_pkg::link_status_t link_status,
	input  gmii_pkg::rgmii_ddr_t   rgmii_tx,
	input  logic                   wr,
	input  logic                   full,
	input  logic                   rd
);

	import gmii_pkg::*;

	// tx en only comes up for a byte popped from the FIFO two cycles earlier
	en_only_after_read: assert property (@(posedge gmii_rxc) disable iff (oserdes_rst)
		$rose(rgmii_tx.ctl_rise) |-> $past(rd, 2))
		else $error("tx en rose with no byte read from the FIFO");

	// At 10/100 a byte takes two nibble cycles
	dvalid_alternates: assert property (@(posedge gmii_rxc) disable iff (oserdes_rst)
		(link_status.link_speed != LINK_SPEED_1000M && gmii_rx.dvalid) |=> !gmii_rx.dvalid)
		else $error("dvalid high on two consecutive cycles at 10/100");

	no_write_when_full: assert property (@(posedge gmii_rxc) disable iff (oserdes_rst)
		wr |-> !full)
		else $error("FIFO written while full");

endmodule

bind rgmii_loopback_bridge rgmii_bridge_assertions asrt_i (
	.gmii_rxc    (gmii_rxc),
	.oserdes_rst (oserdes_rst),
	.gmii_rx     (gmii_rx),
	.link_status (link_status),
	.rgmii_tx    (rgmii_tx),
	.wr          (wr),
	.full        (full),
	.rd          (rd)
);

// File: test/rgmii_bridge_tb.sv
module rgmii_bridge_tb;

	import gmii_pkg::*;
	import link_pkg::*;

	localparam int CLK_PERIOD  = 20;
	localparam int NUM_FRAMES  = 3;
	localparam int MAX_LEN_GIG = 32;
	// Frame cycles over all speeds, two frames more for the back to back pair
	localparam int FRAME_CYCLES = 3 * (NUM_FRAMES + 2) * MAX_LEN_GIG * 2;
	localparam int MARGIN_CYCLES = 5000;

	typedef rgmii_ddr_t cycle_q_t[$];
	typedef fifo_word_t word_q_t[$];

	logic                gmii_rxc;
	logic                oserdes_rst;
	rgmii_ddr_t          rgmii_rx;
	rgmii_ddr_t          rgmii_tx;
	logic [3:0]          txc_pattern;
	link_status_t        link_status;

	// Speed the stimulus has set, read by the compare process
	lspeed_t             cur_speed;
	word_q_t             exp_q;
	bit [31:0]           lcg_state;
	int                  err_cnt;

	rgmii_loopback_bridge #(
		.FIFO_DEPTH (16)
	) dut_i (
		.gmii_rxc    (gmii_rxc),
		.oserdes_rst (oserdes_rst),
		.rgmii_rx    (rgmii_rx),
		.rgmii_tx    (rgmii_tx),
		.txc_pattern (txc_pattern),
		.link_status (link_status)
	);

	initial begin
		gmii_rxc = 1'b0;
		forever #(CLK_PERIOD / 2) gmii_rxc = ~gmii_rxc;
	end

	////////////////////////////////////////////////////////////
	// Helpers

	function automatic bit [31:0] lcg_next();
		lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
		return lcg_state;
	endfunction

	// Gap cycle, bit 0 link state, bits 2:1 speed
	function automatic rgmii_ddr_t gap_word(input logic up, input lspeed_t speed);
		rgmii_ddr_t v;
		v.rxd_rise = {1'b0, speed, up};
		v.rxd_fall = {1'b0, speed, up};
		v.ctl_rise = 1'b0;
		v.ctl_fall = 1'b0;
		return v;
	endfunction

	// Bytes from driven pin cycles, er where ctl_fall differs from ctl_rise
	function automatic word_q_t expected_frame(input cycle_q_t cyc, input lspeed_t speed);
		word_q_t    q;
		fifo_word_t w;
		if (speed == LINK_SPEED_1000M) begin
			foreach (cyc[i]) begin
				w.data = {cyc[i].rxd_fall, cyc[i].rxd_rise};
				w.er   = cyc[i].ctl_rise ^ cyc[i].ctl_fall;
				q.push_back(w);
			end
		end else begin
			// Two nibble cycles per byte, low nibble first
			for (int i = 0; i + 1 < cyc.size(); i += 2) begin
				w.data = {cyc[i + 1].rxd_rise, cyc[i].rxd_rise};
				w.er   = (cyc[i].ctl_rise ^ cyc[i].ctl_fall)
					| (cyc[i + 1].ctl_rise ^ cyc[i + 1].ctl_fall);
				q.push_back(w);
			end
		end
		return q;
	endfunction

	// Forwarded clock pattern at a position inside a nibble hold
	function automatic logic [3:0] expected_txc(input lspeed_t speed, input int pos);
		if (speed == LINK_SPEED_1000M) begin
			return 4'b1001;
		end else if (speed == LINK_SPEED_100M) begin
			if (pos < 2) begin
				return 4'b0000;
			end else if (pos == 2) begin
				return 4'b1100;
			end
			return 4'b1111;
		end
		return (pos < 25) ? 4'b0000 : 4'b1111;
	endfunction

	task automatic fail_run(input string why);
		$display("%s", why);
		$display("Done: errors found");
		$fatal(1, "simulation stopped");
	endtask

	task automatic check(input logic [31:0] got, input logic [31:0] want, input string what);
		if (got !== want) begin
			err_cnt++;
			$display("ERROR at time %0t: %s, got %0h expected %0h", $time, what, got, want);
			fail_run("A check failed");
		end
	endtask

	////////////////////////////////////////////////////////////
	// Stimulus tasks

	task automatic drive(input rgmii_ddr_t v);
		@(posedge gmii_rxc);
		rgmii_rx <= v;
	endtask

	task automatic send_gap(input int n);
		repeat (n) drive(gap_word(1'b1, cur_speed));
	endtask

	task automatic send_frame(input int len);
		cycle_q_t   cyc;
		word_q_t    exp;
		bit [31:0]  r;
		rgmii_ddr_t v;
		for (int i = 0; i < len; i++) begin
			r = lcg_next();
			v.ctl_rise = 1'b1;
			// About one byte in eight carries an error
			v.ctl_fall = (r[27:25] != 3'd0);
			if (cur_speed == LINK_SPEED_1000M) begin
				v.rxd_rise = r[19:16];
				v.rxd_fall = r[23:20];
				cyc.push_back(v);
			end else begin
				v.rxd_rise = r[19:16];
				v.rxd_fall = r[19:16];
				cyc.push_back(v);
				v.rxd_rise = r[23:20];
				v.rxd_fall = r[23:20];
				cyc.push_back(v);
			end
		end
		// Expected bytes queued before the first one can come out
		exp = expected_frame(cyc, cur_speed);
		foreach (exp[i]) exp_q.push_back(exp[i]);
		foreach (cyc[i]) drive(cyc[i]);
	endtask

	function automatic int random_len();
		bit [31:0] r;
		r = lcg_next();
		// Slow frames stay short so the FIFO never fills
		if (cur_speed == LINK_SPEED_1000M) begin
			return 1 + int'(r[12:8]);
		end
		return 1 + int'(r[10:8]);
	endfunction

	// Wait for all bytes, then tx en must stay low
	task automatic drain_and_idle();
		while (exp_q.size() != 0) @(posedge gmii_rxc);
		repeat (110) @(posedge gmii_rxc);
		repeat (16) begin
			@(negedge gmii_rxc);
			check(32'(rgmii_tx), 32'd0, "tx not idle after drain");
		end
	endtask

	// Status follows a gap symbol one cycle after it is decoded
	task automatic step_link(input lspeed_t speed);
		link_status_t prev;
		link_status_t want;
		prev = link_status;
		want = '{link_up: 1'b1, link_speed: speed, false_carrier: 1'b0};
		drive(gap_word(1'b1, speed));
		@(posedge gmii_rxc);
		@(negedge gmii_rxc);
		check(32'(prev), 32'(link_status), "status changed too early");
		@(posedge gmii_rxc);
		@(negedge gmii_rxc);
		check(32'(link_status), 32'(want), "link status after gap symbol");
		cur_speed = speed;
	endtask

	task automatic false_carrier_test();
		rgmii_ddr_t fc;
		int         pulses;
		fc = '{rxd_rise: 4'hE, rxd_fall: 4'h0, ctl_rise: 1'b0, ctl_fall: 1'b1};
		pulses = 0;
		for (int i = 0; i < 12; i++) begin
			drive((i < 3) ? fc : gap_word(1'b1, cur_speed));
			@(negedge gmii_rxc);
			if (link_status.false_carrier) pulses++;
		end
		check(32'(pulses), 32'd1, "false carrier pulse count");
	endtask

	task automatic run_speed(input lspeed_t speed);
		step_link(speed);
		send_gap(8);
		for (int f = 0; f < NUM_FRAMES; f++) begin
			send_frame(random_len());
			send_gap(12);
			if (cur_speed != LINK_SPEED_1000M) drain_and_idle();
		end
		drain_and_idle();
		// Back to back pair with a short gap
		send_frame(random_len());
		send_gap(2);
		send_frame(random_len());
		send_gap(4);
		drain_and_idle();
	endtask

	////////////////////////////////////////////////////////////
	// Compare process

	initial begin : compare
		int         idx;
		int         hold;
		int         pos;
		logic [3:0] held;
		logic [3:0] low_nib;
		fifo_word_t want;
		idx = 0;
		held = '0;
		low_nib = '0;
		forever begin
			@(negedge gmii_rxc);
			if (oserdes_rst || !rgmii_tx.ctl_rise) begin
				idx = 0;
			end else begin
				pos = 0;
				hold = (cur_speed == LINK_SPEED_100M) ? 5 : 50;
				if (cur_speed != LINK_SPEED_1000M) pos = idx % hold;
				check(32'(txc_pattern), 32'(expected_txc(cur_speed, pos)), "txc pattern");
				if (cur_speed == LINK_SPEED_1000M) begin
					if (exp_q.size() == 0) fail_run("Unexpected byte on rgmii_tx");
					want = exp_q.pop_front();
					check(32'({rgmii_tx.rxd_fall, rgmii_tx.rxd_rise}), 32'(want.data), "byte");
					check(32'(rgmii_tx.ctl_rise ^ rgmii_tx.ctl_fall), 32'(want.er), "er");
				end else begin
					check(32'(rgmii_tx.rxd_fall), 32'(rgmii_tx.rxd_rise), "rise and fall differ");
					if (pos != 0) begin
						check(32'(rgmii_tx.rxd_rise), 32'(held), "nibble not held");
					end else if ((idx / hold) % 2 == 0) begin
						held = rgmii_tx.rxd_rise;
						low_nib = rgmii_tx.rxd_rise;
					end else begin
						held = rgmii_tx.rxd_rise;
						if (exp_q.size() == 0) fail_run("Unexpected byte on rgmii_tx");
						want = exp_q.pop_front();
						check(32'({rgmii_tx.rxd_rise, low_nib}), 32'(want.data), "byte");
						check(32'(rgmii_tx.ctl_rise ^ rgmii_tx.ctl_fall), 32'(want.er), "er");
					end
					idx++;
				end
			end
		end
	end

	// Watchdog sized from the frame cycles
	initial begin
		#((FRAME_CYCLES * 60 + MARGIN_CYCLES) * CLK_PERIOD);
		fail_run("Timeout: the run did not finish in time");
	end

	////////////////////////////////////////////////////////////
	// Main sequence

	initial begin
		lcg_state   = 32'd3;
		err_cnt     = 0;
		cur_speed   = LINK_SPEED_10M;
		oserdes_rst = 1'b1;
		rgmii_rx    = '0;
		repeat (5) @(posedge gmii_rxc);
		oserdes_rst <= 1'b0;
		@(negedge gmii_rxc);
		check(32'(rgmii_tx), 32'd0, "tx after reset");
		check(32'(link_status), 32'(link_status_t'('0)), "status after reset");
		// Walk through each speed, then false carrier
		step_link(LINK_SPEED_100M);
		step_link(LINK_SPEED_1000M);
		step_link(LINK_SPEED_10M);
		false_carrier_test();
		run_speed(LINK_SPEED_1000M);
		run_speed(LINK_SPEED_100M);
		run_speed(LINK_SPEED_10M);
		if (err_cnt == 0) begin
			$display("Done: no errors");
		end else begin
			$display("Done: errors found");
		end
		$finish;
	end

endmodule
